//--- hw/cpu_pkg.sv
package cpu_pkg;

    // status byte bit positions
    localparam int unsigned FLAG_C = 0;
    localparam int unsigned FLAG_Z = 1;
    localparam int unsigned FLAG_V = 6;
    localparam int unsigned FLAG_N = 7;

    // 6502 opcode fields aaa_bbb_cc
    typedef struct packed {
        logic [2:0] aaa;
        logic [2:0] bbb;
        logic [1:0] cc;
    } opcode_f_t;

    typedef union packed {
        logic [7:0] raw;
        opcode_f_t  f;
    } opcode_u;

    typedef enum logic [2:0] {
        ALU_OR, ALU_AND, ALU_EOR, ALU_ADC, ALU_SBC, ALU_CMP, ALU_PASS, ALU_ADD_ADDR
    } alu_op_e;

    typedef enum logic [2:0] {
        ADDR_PC, ADDR_DATA, ADDR_EA_LATCH, ADDR_ZERO, ADDR_HOLD
    } addr_sel_e;

    typedef enum logic [2:0] {
        MODE_IMM, MODE_ZPG, MODE_ABS, MODE_BRANCH, MODE_JUMP, MODE_FLAG, MODE_ILLEGAL
    } mode_e;

    typedef struct packed {
        mode_e      mode;
        alu_op_e    alu_op;
        logic       load_a;
        logic       store_a;
        logic       set_nz;
        logic       set_c;
        logic       set_v;
        logic [1:0] br_flag;   // 00 N, 01 V, 10 C, 11 Z
        logic       br_pol;    // branch when flag equals this
        logic [1:0] c_write;   // bit 1 enables, bit 0 is the new carry
    } dec_t;

    typedef struct packed {
        addr_sel_e adl_sel;
        addr_sel_e adh_sel;
        logic      pc_inc;
        logic      pc_load;
        logic      ir_load;
        logic      ea_lo_load;
        logic      exec;
        logic      we;
        logic      branch_add;
        logic      page_fix;
    } ctrl_t;

endpackage

//--- hw/cpu_alu.sv
`timescale 1ns/10ps

module cpu_alu (
    input  cpu_pkg::alu_op_e op_i,
    input  logic [7:0]       a_i,
    input  logic [7:0]       b_i,
    input  logic             c_i,
    output logic [7:0]       y_o,
    output logic             c_o,
    output logic             v_o
);

    logic [7:0] b_eff;
    logic       c_in;
    logic [8:0] sum;

    always_comb begin
        // subtract is add of the inverted operand
        b_eff = (op_i == cpu_pkg::ALU_SBC || op_i == cpu_pkg::ALU_CMP) ? ~b_i : b_i;
        case (op_i)
            cpu_pkg::ALU_ADC, cpu_pkg::ALU_SBC: c_in = c_i;
            cpu_pkg::ALU_CMP:                   c_in = 1'b1;
            default:                            c_in = 1'b0;
        endcase
        sum = {1'b0, a_i} + {1'b0, b_eff} + {8'h00, c_in};
        c_o = sum[8];
        // signed overflow when both inputs agree in sign and the result does not
        v_o = (a_i[7] == b_eff[7]) && (sum[7] != a_i[7]);
        case (op_i)
            cpu_pkg::ALU_OR:   y_o = a_i | b_i;
            cpu_pkg::ALU_AND:  y_o = a_i & b_i;
            cpu_pkg::ALU_EOR:  y_o = a_i ^ b_i;
            cpu_pkg::ALU_PASS: y_o = b_i;
            default:           y_o = sum[7:0];
        endcase
    end

endmodule

//--- hw/cpu_decode.sv
`timescale 1ns/10ps

module cpu_decode (
    input  cpu_pkg::opcode_u opcode_i,
    output cpu_pkg::dec_t    dec_o
);

    always_comb begin
        dec_o = '0;
        dec_o.mode = cpu_pkg::MODE_ILLEGAL;
        dec_o.alu_op = cpu_pkg::ALU_PASS;
        if (opcode_i.f.cc == 2'b01) begin
            case (opcode_i.f.bbb)
                3'b001:  dec_o.mode = cpu_pkg::MODE_ZPG;
                3'b010:  dec_o.mode = cpu_pkg::MODE_IMM;
                3'b011:  dec_o.mode = cpu_pkg::MODE_ABS;
                default: dec_o.mode = cpu_pkg::MODE_ILLEGAL;
            endcase
            case (opcode_i.f.aaa)
                3'b000:  dec_o.alu_op = cpu_pkg::ALU_OR;
                3'b001:  dec_o.alu_op = cpu_pkg::ALU_AND;
                3'b010:  dec_o.alu_op = cpu_pkg::ALU_EOR;
                3'b011:  dec_o.alu_op = cpu_pkg::ALU_ADC;
                3'b110:  dec_o.alu_op = cpu_pkg::ALU_CMP;
                3'b111:  dec_o.alu_op = cpu_pkg::ALU_SBC;
                default: dec_o.alu_op = cpu_pkg::ALU_PASS;
            endcase
            dec_o.store_a = (opcode_i.f.aaa == 3'b100);
            dec_o.load_a = (opcode_i.f.aaa != 3'b100) && (opcode_i.f.aaa != 3'b110);
            dec_o.set_nz = (opcode_i.f.aaa != 3'b100);
            dec_o.set_c = opcode_i.f.aaa inside {3'b011, 3'b110, 3'b111};
            dec_o.set_v = opcode_i.f.aaa inside {3'b011, 3'b111};
            // no STA immediate
            if (dec_o.store_a && opcode_i.f.bbb == 3'b010) begin
                dec_o.mode = cpu_pkg::MODE_ILLEGAL;
            end
        end else if (opcode_i.raw[4:0] == 5'b10000) begin
            dec_o.mode = cpu_pkg::MODE_BRANCH;
            dec_o.alu_op = cpu_pkg::ALU_ADD_ADDR;
            dec_o.br_flag = opcode_i.raw[7:6];
            dec_o.br_pol = opcode_i.raw[5];
        end else if (opcode_i.raw == 8'h4c) begin
            dec_o.mode = cpu_pkg::MODE_JUMP;
        end else if (opcode_i.raw == 8'h18 || opcode_i.raw == 8'h38) begin
            // CLC / SEC differ only in bit 5
            dec_o.mode = cpu_pkg::MODE_FLAG;
            dec_o.c_write = {1'b1, opcode_i.raw[5]};
        end
    end

endmodule

//--- hw/cpu_sequencer.sv
`timescale 1ns/10ps

module cpu_sequencer (
    input  logic           clk,
    input  logic           rst,
    input  cpu_pkg::dec_t  dec_i,
    input  logic [7:0]     flags_i,
    input  logic           page_cross_i,
    output cpu_pkg::ctrl_t ctrl_o,
    output logic           sync_o,
    output logic           jam_o
);

    localparam logic [3:0] T1 = 4'b0001;
    localparam logic [3:0] T2 = 4'b0010;
    localparam logic [3:0] T3 = 4'b0100;
    localparam logic [3:0] T4 = 4'b1000;

    logic [3:0] t_state;
    logic [3:0] t_next;
    logic       flag_bit;
    logic       taken;

    always_ff @(posedge clk) begin
        if (rst) begin
            t_state <= T1;
        end else begin
            t_state <= t_next;
        end
    end

    // branch condition
    always_comb begin
        case (dec_i.br_flag)
            2'b00:   flag_bit = flags_i[cpu_pkg::FLAG_N];
            2'b01:   flag_bit = flags_i[cpu_pkg::FLAG_V];
            2'b10:   flag_bit = flags_i[cpu_pkg::FLAG_C];
            default: flag_bit = flags_i[cpu_pkg::FLAG_Z];
        endcase
        taken = (flag_bit == dec_i.br_pol);
    end

    assign sync_o = t_state[0];
    // illegal opcode shows up in T2, state goes dead after that
    assign jam_o = ~|t_state | (t_state[1] & (dec_i.mode == cpu_pkg::MODE_ILLEGAL));

    always_comb begin
        ctrl_o = '0;
        ctrl_o.adl_sel = cpu_pkg::ADDR_PC;
        ctrl_o.adh_sel = cpu_pkg::ADDR_PC;
        t_next = '0;
        case (t_state)
            T1: begin
                ctrl_o.ir_load = 1'b1;
                ctrl_o.pc_inc = 1'b1;
                t_next = T2;
            end
            T2: begin
                case (dec_i.mode)
                    cpu_pkg::MODE_IMM: begin
                        ctrl_o.pc_inc = 1'b1;
                        ctrl_o.exec = 1'b1;
                        t_next = T1;
                    end
                    cpu_pkg::MODE_ZPG: begin
                        ctrl_o.pc_inc = 1'b1;
                        ctrl_o.ea_lo_load = 1'b1;
                        ctrl_o.adl_sel = cpu_pkg::ADDR_DATA;
                        ctrl_o.adh_sel = cpu_pkg::ADDR_ZERO;
                        t_next = T3;
                    end
                    cpu_pkg::MODE_ABS, cpu_pkg::MODE_JUMP: begin
                        ctrl_o.pc_inc = 1'b1;
                        ctrl_o.ea_lo_load = 1'b1;
                        t_next = T3;
                    end
                    cpu_pkg::MODE_BRANCH: begin
                        ctrl_o.pc_inc = 1'b1;
                        // taken: re-read the offset while pc moves past it
                        if (taken) begin
                            ctrl_o.adl_sel = cpu_pkg::ADDR_HOLD;
                            ctrl_o.adh_sel = cpu_pkg::ADDR_HOLD;
                            t_next = T3;
                        end else begin
                            t_next = T1;
                        end
                    end
                    cpu_pkg::MODE_FLAG: begin
                        ctrl_o.exec = 1'b1;
                        t_next = T1;
                    end
                    default: t_next = '0;
                endcase
            end
            T3: begin
                case (dec_i.mode)
                    cpu_pkg::MODE_ZPG: begin
                        ctrl_o.exec = ~dec_i.store_a;
                        ctrl_o.we = dec_i.store_a;
                        t_next = T1;
                    end
                    cpu_pkg::MODE_ABS: begin
                        // pc steps past the high operand byte
                        ctrl_o.pc_inc = 1'b1;
                        ctrl_o.adl_sel = cpu_pkg::ADDR_EA_LATCH;
                        ctrl_o.adh_sel = cpu_pkg::ADDR_DATA;
                        t_next = T4;
                    end
                    cpu_pkg::MODE_JUMP: begin
                        ctrl_o.adl_sel = cpu_pkg::ADDR_EA_LATCH;
                        ctrl_o.adh_sel = cpu_pkg::ADDR_DATA;
                        ctrl_o.pc_load = 1'b1;
                        t_next = T1;
                    end
                    cpu_pkg::MODE_BRANCH: begin
                        ctrl_o.branch_add = 1'b1;
                        t_next = page_cross_i ? T4 : T1;
                    end
                    default: t_next = '0;
                endcase
            end
            T4: begin
                case (dec_i.mode)
                    cpu_pkg::MODE_ABS: begin
                        ctrl_o.exec = ~dec_i.store_a;
                        ctrl_o.we = dec_i.store_a;
                        t_next = T1;
                    end
                    cpu_pkg::MODE_BRANCH: begin
                        ctrl_o.page_fix = 1'b1;
                        t_next = T1;
                    end
                    default: t_next = '0;
                endcase
            end
            default: t_next = '0;
        endcase
    end

    assert property (@(posedge clk) disable iff (rst) $onehot0(t_state));
    assert property (@(posedge clk) disable iff (rst) !(sync_o && ctrl_o.we));

endmodule

//--- hw/cpu_regs.sv
`timescale 1ns/10ps

module cpu_regs (
    input  logic             clk,
    input  logic             rst,
    input  cpu_pkg::ctrl_t   ctrl_i,
    input  cpu_pkg::dec_t    dec_i,
    input  logic [7:0]       data_i,
    input  logic [7:0]       pcl_i,
    output cpu_pkg::opcode_u opcode_o,
    output logic [7:0]       flags_o,
    output logic [7:0]       alu_o,
    output logic             alu_c_o,
    output logic [7:0]       data_o
);

    logic [7:0] acc;
    logic [7:0] status;
    logic [7:0] alu_a;
    logic       alu_v;

    // branch add works on the low pc byte instead of A
    assign alu_a = ctrl_i.branch_add ? pcl_i : acc;

    cpu_alu u_alu (
        .op_i(dec_i.alu_op), .a_i(alu_a), .b_i(data_i), .c_i(status[cpu_pkg::FLAG_C]),
        .y_o(alu_o), .c_o(alu_c_o), .v_o(alu_v)
    );

    always_ff @(posedge clk) begin
        if (ctrl_i.ir_load) begin
            opcode_o <= data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
            status <= '0;
        end else if (ctrl_i.exec) begin
            if (dec_i.load_a) begin
                acc <= alu_o;
            end
            if (dec_i.set_nz) begin
                status[cpu_pkg::FLAG_Z] <= (alu_o == 8'h00);
                status[cpu_pkg::FLAG_N] <= alu_o[7];
            end
            if (dec_i.set_c) begin
                status[cpu_pkg::FLAG_C] <= alu_c_o;
            end
            if (dec_i.set_v) begin
                status[cpu_pkg::FLAG_V] <= alu_v;
            end
            if (dec_i.c_write[1]) begin
                status[cpu_pkg::FLAG_C] <= dec_i.c_write[0];
            end
        end
    end

    assign flags_o = status;
    assign data_o = acc;

    assert property (@(posedge clk) disable iff (rst) !(ctrl_i.exec && ctrl_i.ir_load));

endmodule

//--- hw/cpu_addr.sv
`timescale 1ns/10ps

module cpu_addr #(
    parameter logic [15:0] RST_ADDR = 16'h0200
) (
    input  logic           clk,
    input  logic           rst,
    input  cpu_pkg::ctrl_t ctrl_i,
    input  logic [7:0]     data_i,
    input  logic [7:0]     alu_i,
    input  logic           alu_c_i,
    input  logic           offset_neg_i,
    output logic [7:0]     pcl_o,
    output logic           page_cross_o,
    output logic [15:0]    addr_o
);

    logic [15:0] pc;
    logic [15:0] pc_next;
    logic [7:0]  ea_lo;
    logic [7:0]  adl;
    logic [7:0]  adh;
    logic        fix_down;

    function automatic logic [7:0] pick_byte(input cpu_pkg::addr_sel_e sel,
                                             input logic [7:0] pc_b,
                                             input logic [7:0] hold_b,
                                             input logic [7:0] data_b,
                                             input logic [7:0] ea_b);
        logic [7:0] b;
        case (sel)
            cpu_pkg::ADDR_DATA:     b = data_b;
            cpu_pkg::ADDR_EA_LATCH: b = ea_b;
            cpu_pkg::ADDR_ZERO:     b = 8'h00;
            cpu_pkg::ADDR_HOLD:     b = hold_b;
            default:                b = pc_b;
        endcase
        return b;
    endfunction

    always_comb begin
        pc_next = pc;
        if (ctrl_i.pc_inc) begin
            pc_next = pc + 16'd1;
        end
        // branch target low byte, high byte fixed a cycle later if needed
        if (ctrl_i.branch_add) begin
            pc_next[7:0] = alu_i;
        end
        if (ctrl_i.page_fix) begin
            pc_next[15:8] = fix_down ? pc[15:8] - 8'd1 : pc[15:8] + 8'd1;
        end
        adl = pick_byte(ctrl_i.adl_sel, pc_next[7:0], addr_o[7:0], data_i, ea_lo);
        adh = pick_byte(ctrl_i.adh_sel, pc_next[15:8], addr_o[15:8], data_i, ea_lo);
    end

    // carry out against offset sign tells if the page changed
    assign page_cross_o = ctrl_i.branch_add & (alu_c_i ^ offset_neg_i);
    assign pcl_o = pc[7:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RST_ADDR;
            addr_o <= RST_ADDR;
            fix_down <= 1'b0;
        end else begin
            addr_o <= {adh, adl};
            pc <= ctrl_i.pc_load ? {adh, adl} : pc_next;
            if (ctrl_i.branch_add) begin
                fix_down <= offset_neg_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl_i.ea_lo_load) begin
            ea_lo <= data_i;
        end
    end

    // store address low byte is the one latched from the operand
    assert property (@(posedge clk) disable iff (rst) ctrl_i.we |-> addr_o[7:0] == ea_lo);

endmodule

//--- hw/cpu_top.sv
`timescale 1ns/10ps

module cpu_top #(
    parameter logic [15:0] RST_ADDR = 16'h0200
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  data_i,
    output logic [15:0] addr_o,
    output logic [7:0]  data_o,
    output logic        we_o,
    output logic        sync_o,
    output logic        jam_o
);

    cpu_pkg::ctrl_t  ctrl;
    cpu_pkg::dec_t   dec;
    cpu_pkg::opcode_u opcode;
    logic [7:0]      flags;
    logic [7:0]      alu_y;
    logic            alu_c;
    logic [7:0]      pcl;
    logic            page_cross;

    assign we_o = ctrl.we;

    cpu_sequencer u_seq (
        .clk(clk), .rst(rst), .dec_i(dec), .flags_i(flags), .page_cross_i(page_cross),
        .ctrl_o(ctrl), .sync_o(sync_o), .jam_o(jam_o)
    );

    cpu_decode u_dec (.opcode_i(opcode), .dec_o(dec));

    cpu_regs u_regs (
        .clk(clk), .rst(rst), .ctrl_i(ctrl), .dec_i(dec), .data_i(data_i), .pcl_i(pcl),
        .opcode_o(opcode), .flags_o(flags), .alu_o(alu_y), .alu_c_o(alu_c), .data_o(data_o)
    );

    // branch offset sign comes straight off the data bus
    cpu_addr #(.RST_ADDR(RST_ADDR)) u_addr (
        .clk(clk), .rst(rst), .ctrl_i(ctrl), .data_i(data_i), .alu_i(alu_y),
        .alu_c_i(alu_c), .offset_neg_i(data_i[7]), .pcl_o(pcl),
        .page_cross_o(page_cross), .addr_o(addr_o)
    );

endmodule

//--- bench/tb_model.svh
logic [31:0] lfsr_state = 32'haf22_ac61;
logic [7:0]  mem [0:65535];
logic [7:0]  mmem [0:65535];
logic [7:0]  init_mem [0:65535];

// reference model state
logic [15:0] m_pc;
logic [7:0]  m_a;
logic        m_c;
logic        m_z;
logic        m_v;
logic        m_n;
logic        m_st;
logic [15:0] m_st_addr;
logic [7:0]  m_st_data;

// galois form, one output bit per step
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[30:0], lfsr_state[0]};
        lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
    return r;
endfunction

task automatic model_reset();
    for (int i = 0; i < 65536; i++) begin
        mmem[i] = init_mem[i];
    end
    m_pc = RST_ADDR;
    m_a = 8'h00;
    {m_c, m_z, m_v, m_n} = 4'b0000;
    m_st = 1'b0;
endtask

task automatic add_with_carry(input logic [7:0] b);
    logic [8:0] s;
    s = {1'b0, m_a} + {1'b0, b} + {8'h00, m_c};
    m_v = (m_a[7] == b[7]) && (s[7] != m_a[7]);
    m_c = s[8];
    m_a = s[7:0];
endtask

// one instruction, as the 6502 would run it
task automatic model_step();
    logic [7:0]  op;
    logic [7:0]  b1;
    logic [7:0]  b2;
    logic [7:0]  m;
    logic [8:0]  s;
    logic [15:0] ea;
    logic        flag;
    op = mmem[m_pc];
    b1 = mmem[m_pc + 16'd1];
    b2 = mmem[m_pc + 16'd2];
    m_st = 1'b0;
    if (op[1:0] == 2'b01) begin
        ea = (op[4:2] == 3'b011) ? {b2, b1} : {8'h00, b1};
        m = (op[4:2] == 3'b010) ? b1 : mmem[ea];
        // absolute carries two operand bytes
        m_pc = m_pc + ((op[4:2] == 3'b011) ? 16'd3 : 16'd2);
        case (op[7:5])
            3'd0: m_a = m_a | m;
            3'd1: m_a = m_a & m;
            3'd2: m_a = m_a ^ m;
            3'd3: add_with_carry(m);
            3'd4: begin
                m_st = 1'b1;
                m_st_addr = ea;
                m_st_data = m_a;
                mmem[ea] = m_a;
            end
            3'd5: m_a = m;
            3'd6: begin
                s = {1'b0, m_a} + {1'b0, ~m} + 9'd1;
                m_c = s[8];
                m_z = (s[7:0] == 8'h00);
                m_n = s[7];
            end
            default: add_with_carry(~m);
        endcase
        if (op[7:5] != 3'd4 && op[7:5] != 3'd6) begin
            m_z = (m_a == 8'h00);
            m_n = m_a[7];
        end
    end else if (op[4:0] == 5'b10000) begin
        case (op[7:6])
            2'b00:   flag = m_n;
            2'b01:   flag = m_v;
            2'b10:   flag = m_c;
            default: flag = m_z;
        endcase
        m_pc = m_pc + 16'd2;
        if (flag == op[5]) begin
            m_pc = m_pc + {{8{b1[7]}}, b1};
        end
    end else if (op == 8'h4c) begin
        m_pc = {b2, b1};
    end else begin
        m_c = op[5];
        m_pc = m_pc + 16'd1;
    end
endtask

task automatic put_byte(input logic [15:0] a, input logic [7:0] v);
    init_mem[a] = v;
    mmem[a] = v;
endtask

// code grows forward only, generated along the path the model takes
task automatic build_program(input int count);
    logic [31:0] r;
    logic [15:0] ad;
    logic [15:0] target;
    logic [7:0]  op;
    logic [2:0]  bbb;
    for (int a = 0; a < 65536; a++) begin
        ad = a[15:0];
        init_mem[a] = ad[7:0] ^ {ad[12:8], ad[15:13]} ^ 8'h5a;
    end
    model_reset();
    for (int i = 0; i < count; i++) begin
        r = rand_bits(9);
        if (r[8:5] == 4'd10 || r[8:5] == 4'd11) begin
            op = {r[2:0], 5'b10000};
        end else if (r[8:5] == 4'd12) begin
            op = 8'h4c;
        end else if (r[8:5] == 4'd13) begin
            op = r[0] ? 8'h38 : 8'h18;
        end else begin
            bbb = (r[1:0] == 2'd0) ? 3'b001 : (r[1:0] == 2'd1) ? 3'b010 : 3'b011;
            // STA has no immediate form
            if (r[4:2] == 3'd4 && bbb == 3'b010) begin
                bbb = 3'b001;
            end
            op = {r[4:2], bbb, 2'b01};
        end
        put_byte(m_pc, op);
        r = rand_bits(8);
        if (op == 8'h4c) begin
            target = m_pc + 16'd3 + {8'h00, r[7:0]};
            put_byte(m_pc + 16'd1, target[7:0]);
            put_byte(m_pc + 16'd2, target[15:8]);
        end else if (op[4:0] == 5'b10000) begin
            put_byte(m_pc + 16'd1, {1'b0, r[6:0]});
        end else if (op[1:0] == 2'b01) begin
            put_byte(m_pc + 16'd1, r[7:0]);
            if (op[4:2] == 3'b011) begin
                // data pages stay below the code
                r = rand_bits(7);
                put_byte(m_pc + 16'd2, {1'b0, r[6:0]});
            end
        end
        model_step();
    end
endtask

//--- bench/tb_top.sv
`timescale 1ns/10ps

module tb_top;

    localparam logic [15:0] RST_ADDR = 16'h8000;
    localparam int N_INSTR = 500;
    localparam int STEP_TIMEOUT = 8;
    localparam int JAM_TIMEOUT = 8;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic [7:0]  data_i;
    logic [15:0] addr_o;
    logic [7:0]  data_o;
    logic        we_o;
    logic        sync_o;
    logic        jam_o;

    `include "tb_model.svh"

    always #2 clk = ~clk;

    cpu_top #(.RST_ADDR(RST_ADDR)) dut (
        .clk(clk), .rst(rst), .data_i(data_i), .addr_o(addr_o), .data_o(data_o),
        .we_o(we_o), .sync_o(sync_o), .jam_o(jam_o)
    );

    // asynchronous read, write on the edge
    assign data_i = mem[addr_o];

    always @(posedge clk) begin
        if (we_o) begin
            mem[addr_o] <= data_o;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic reset_dut();
        @(posedge clk);
        rst <= 1'b1;
        for (int i = 1; i <= 10; i++) begin
            @(negedge clk);
            if (i == 2) begin
                for (int a = 0; a < 65536; a++) begin
                    mem[a] = init_mem[a];
                end
            end
            if (i >= 2) begin
                check_value("we_o", we_o, 0);
                check_value("jam_o", jam_o, 0);
            end
            @(posedge clk);
        end
        rst <= 1'b0;
    endtask

    task automatic first_sync();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            check_value("we_o", we_o, 0);
            check_value("jam_o", jam_o, 0);
        end while (!sync_o && n < STEP_TIMEOUT);
        if (!sync_o) begin
            abort_run("no sync_o came after reset");
        end
        check_value("addr_o", addr_o, RST_ADDR);
    endtask

    // entered on a sync cycle, returns on the next one
    task automatic run_instr();
        int n;
        int pulses;
        logic [15:0] start_pc;
        start_pc = m_pc;
        check_value("addr_o", addr_o, m_pc);
        model_step();
        n = 0;
        pulses = 0;
        do begin
            @(negedge clk);
            n++;
            if (we_o) begin
                pulses++;
                check_value("addr_o", addr_o, m_st_addr);
                check_value("data_o", data_o, m_st_data);
            end
            check_value("jam_o", jam_o, 0);
        end while (!sync_o && n < STEP_TIMEOUT);
        if (!sync_o) begin
            abort_run($sformatf("no sync_o after the instruction at %h", start_pc));
        end
        check_value("we_o", pulses, m_st);
    endtask

    initial begin
        logic [31:0] r;
        logic [15:0] bad_pc;
        int          n2;
        int          n;
        build_program(N_INSTR + 20);
        reset_dut();
        model_reset();
        first_sync();
        repeat (N_INSTR) run_instr();

        // second run ends on a planted illegal opcode
        r = rand_bits(5);
        model_reset();
        n2 = 0;
        while (n2 < 20 + int'(r[4:0])) begin
            model_step();
            n2++;
        end
        bad_pc = m_pc;
        init_mem[bad_pc] = 8'h02;
        model_reset();
        reset_dut();
        first_sync();
        repeat (n2) run_instr();
        check_value("addr_o", addr_o, bad_pc);
        n = 0;
        while (!jam_o && n < JAM_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!jam_o) begin
            abort_run("jam_o never rose after the illegal opcode");
        end
        repeat (20) begin
            @(negedge clk);
            check_value("sync_o", sync_o, 0);
            check_value("we_o", we_o, 0);
            check_value("jam_o", jam_o, 1);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+bench
hw/cpu_pkg.sv
hw/cpu_alu.sv
hw/cpu_decode.sv
hw/cpu_sequencer.sv
hw/cpu_regs.sv
hw/cpu_addr.sv
hw/cpu_top.sv
bench/tb_top.sv
